// ==== tb.f ====
+incdir+sim
rtl/isaPkg.sv
rtl/sysPkg.sv
rtl/fetchUnit.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/dataMemIo.sv
rtl/controlFsm.sv
rtl/procTop.sv
sim/tbProc.sv

// ==== sim/tbTasks.svh ====
  // Register form field order is op1, op2, unused, rd, rs, rt
  function automatic logic [31:0] regInst(op2_t op2, logic [3:0] rd, logic [3:0] rs,
                                          logic [3:0] rt);
    return {op1Ext, op2, 6'b000000, rd, rs, rt};
  endfunction

  // Immediate form field order is op1, unused, imm, rs, rt
  function automatic logic [31:0] immInst(op1_t op1, logic [3:0] rt, logic [3:0] rs,
                                          logic [15:0] imm);
    return {op1, 2'b00, imm, rs, rt};
  endfunction

  function automatic logic [31:0] widenImm(logic [15:0] imm);
    return {{16{imm[15]}}, imm};
  endfunction

  function automatic logic [31:0] randomBits(int count);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int i = 0; i < count; i++) begin
      // Taps 32, 22, 2, 1
      feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], feedback};
      value = {value[30:0], feedback};
    end
    return value;
  endfunction

  function automatic logic [31:0] aluModel(op2_t op, logic signed [31:0] x,
                                           logic signed [31:0] y);
    case (op)
      op2Eq:   return {31'd0, x == y};
      op2Lt:   return {31'd0, x < y};
      op2Le:   return {31'd0, x <= y};
      op2Ne:   return {31'd0, x != y};
      op2Add:  return x + y;
      op2And:  return x & y;
      op2Or:   return x | y;
      op2Xor:  return x ^ y;
      op2Sub:  return x - y;
      op2Nand: return ~(x & y);
      op2Nor:  return ~(x | y);
      op2Nxor: return ~(x ^ y);
      default: return '0;
    endcase
  endfunction

  function automatic bit branchTaken(op1_t op, logic signed [31:0] x, logic signed [31:0] y);
    case (op)
      op1Beq:  return x == y;
      op1Blt:  return x < y;
      op1Ble:  return x <= y;
      default: return x != y;
    endcase
  endfunction

  task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error at time %0t: %s is %h, expected %h", $time, name, actual, expected);
      errorCount++;
    end
  endtask

  task automatic reportTest(string name, int errorsBefore);
    if (errorCount == errorsBefore) begin
      $display("Test %s: pass", name);
      passCount++;
    end else begin
      $display("Test %s: fail with %0d errors", name, errorCount - errorsBefore);
      failCount++;
    end
  endtask

  // Empty words decode as an unknown op2
  task automatic clearProgram();
    for (int i = 0; i < progDepth; i++) begin
      prog[i] = '0;
    end
    progLen = 0;
  endtask

  task automatic appendInst(logic [31:0] word);
    prog[progLen] = word;
    progLen++;
  endtask

  task automatic sendHex(logic [3:0] r);
    appendInst(immInst(op1Sw, r, 4'd0, addrHex[15:0]));
  endtask

  // r15 is the scratch register for LEDR markers
  task automatic showLedr(logic [15:0] value);
    appendInst(immInst(op1Addi, 4'd15, 4'd0, value));
    appendInst(immInst(op1Sw, 4'd15, 4'd0, addrLedr[15:0]));
  endtask

  task automatic haltHere();
    appendInst(immInst(op1Beq, 4'd0, 4'd0, 16'hFFFF));
  endtask

  task automatic restartDut();
    reset = 1'b1;
    repeat (resetCycles) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic waitForLedr(input logic [9:0] value, output bit found);
    found = 1'b0;
    while (!found && budget > 0) begin
      @(negedge clk);
      budget--;
      if (ledr == value) found = 1'b1;
    end
    if (!found) begin
      $display("Timeout: ledr never showed %h", value);
      errorCount++;
    end
  endtask

  // Each change of ledr marks one LEDR store since consecutive stores differ
  task automatic watchLedrSequence();
    logic [9:0] last;
    last = ledr;
    while (ledrExpect.size() > 0 && budget > 0) begin
      @(negedge clk);
      budget--;
      if (ledr != last) begin
        checkValue("ledr", 32'(ledr), 32'(ledrExpect.pop_front()));
        last = ledr;
      end
    end
    if (ledrExpect.size() > 0) begin
      $display("Timeout: %0d ledr stores still missing", ledrExpect.size());
      errorCount++;
    end
  endtask

  task automatic resetTest();
    int errorsBefore;
    errorsBefore = errorCount;
    clearProgram();
    haltHere();
    reset = 1'b1;
    repeat (resetCycles) @(negedge clk);
    checkValue("ledr", 32'(ledr), 32'h0);
    checkValue("hex", 32'(hex), 32'h0);
    checkValue("instAddr", instAddr, startPc);
    reset = 1'b0;
    // First fetch is still one edge away
    #2;
    checkValue("instAddr", instAddr, startPc);
    checkValue("ledr", 32'(ledr), 32'h0);
    checkValue("hex", 32'(hex), 32'h0);
    @(negedge clk);
    repeat (20) @(negedge clk);
    checkValue("ledr", 32'(ledr), 32'h0);
    checkValue("hex", 32'(hex), 32'h0);
    reportTest("reset", errorsBefore);
  endtask

  task automatic aluTest();
    op2_t        regOps [12];
    op1_t        immOps [4];
    op2_t        immModel [4];
    logic [15:0] immA;
    logic [15:0] immB;
    logic [15:0] immC;
    logic [31:0] expected [20];
    int          errorsBefore;
    bit          found;
    regOps = '{op2Eq, op2Lt, op2Le, op2Ne, op2Add, op2And,
               op2Or, op2Xor, op2Sub, op2Nand, op2Nor, op2Nxor};
    immOps = '{op1Addi, op1Andi, op1Ori, op1Xori};
    immModel = '{op2Add, op2And, op2Or, op2Xor};
    errorsBefore = errorCount;
    immA = 16'(randomBits(16));
    immB = 16'(randomBits(16));
    immC = 16'(randomBits(16));
    clearProgram();
    appendInst(immInst(op1Addi, 4'd1, 4'd0, immA));
    appendInst(immInst(op1Ori, 4'd2, 4'd0, immB));
    for (int i = 0; i < 12; i++) begin
      appendInst(regInst(regOps[i], 4'd3, 4'd1, 4'd2));
      sendHex(4'd3);
      showLedr(16'(i + 1));
      expected[i] = aluModel(regOps[i], widenImm(immA), widenImm(immB));
    end
    for (int i = 0; i < 4; i++) begin
      appendInst(immInst(immOps[i], 4'd3, 4'd1, immC));
      sendHex(4'd3);
      showLedr(16'(i + 13));
      expected[i + 12] = aluModel(immModel[i], widenImm(immA), widenImm(immC));
    end
    // Equal operands tell le from lt and eq from ne
    for (int i = 0; i < 4; i++) begin
      appendInst(regInst(regOps[i], 4'd3, 4'd1, 4'd1));
      sendHex(4'd3);
      showLedr(16'(i + 17));
      expected[i + 16] = aluModel(regOps[i], widenImm(immA), widenImm(immA));
    end
    haltHere();
    restartDut();
    budget = aluBudget;
    for (int i = 0; i < 20; i++) begin
      waitForLedr(10'(i + 1), found);
      if (!found) break;
      checkValue("hex", 32'(hex), expected[i] & 32'h00FFFFFF);
    end
    reportTest("alu", errorsBefore);
  endtask

  task automatic branchTest();
    op1_t        brOps [8];
    logic [3:0]  rsSel [8];
    logic [3:0]  rtSel [8];
    logic [31:0] jalAddr;
    logic [31:0] target;
    int          errorsBefore;
    brOps = '{op1Beq, op1Beq, op1Blt, op1Blt, op1Ble, op1Ble, op1Bne, op1Bne};
    rsSel = '{4'd1, 4'd1, 4'd1, 4'd2, 4'd1, 4'd2, 4'd1, 4'd1};
    rtSel = '{4'd1, 4'd2, 4'd2, 4'd1, 4'd1, 4'd1, 4'd2, 4'd1};
    errorsBefore = errorCount;
    clearProgram();
    ledrExpect.delete();
    // r1 = 1 and r2 = 2 so each register holds its own number
    appendInst(immInst(op1Addi, 4'd1, 4'd0, 16'd1));
    appendInst(immInst(op1Addi, 4'd2, 4'd0, 16'd2));
    for (int i = 0; i < 8; i++) begin
      appendInst(immInst(op1Addi, 4'd15, 4'd0, 16'(64 + i)));
      appendInst(immInst(brOps[i], rtSel[i], rsSel[i], 16'd1));
      appendInst(immInst(op1Sw, 4'd15, 4'd0, addrLedr[15:0]));
      showLedr(16'(128 + i));
      if (!branchTaken(brOps[i], 32'(rsSel[i]), 32'(rtSel[i]))) begin
        ledrExpect.push_back(10'(64 + i));
      end
      ledrExpect.push_back(10'(128 + i));
    end
    // Absolute target past a store that must never run
    jalAddr = startPc + 32'(4 * progLen);
    target = jalAddr + 32'd12;
    appendInst(immInst(op1Jal, 4'd13, 4'd0, target[17:2]));
    showLedr(16'h3FF);
    sendHex(4'd13);
    showLedr(16'h03E);
    haltHere();
    ledrExpect.push_back(10'h03E);
    restartDut();
    budget = branchBudget;
    watchLedrSequence();
    checkValue("hex", 32'(hex), (jalAddr + 32'd4) & 32'h00FFFFFF);
    reportTest("branch", errorsBefore);
  endtask

  task automatic memoryTest();
    logic [3:0]  bases [5];
    logic [15:0] offsets [5];
    logic [15:0] patterns [5];
    int          errorsBefore;
    bit          found;
    bases = '{4'd0, 4'd0, 4'd0, 4'd5, 4'd5};
    offsets = '{16'h0000, 16'h0124, 16'h7FFC, 16'h7FF8, 16'h0010};
    errorsBefore = errorCount;
    clearProgram();
    // r5 = 0x8000 reaches the upper half of the data memory
    appendInst(immInst(op1Addi, 4'd5, 4'd0, 16'h4000));
    appendInst(regInst(op2Add, 4'd5, 4'd5, 4'd5));
    for (int i = 0; i < 5; i++) begin
      patterns[i] = 16'(randomBits(16));
      appendInst(immInst(op1Addi, 4'd6, 4'd0, patterns[i]));
      appendInst(immInst(op1Sw, 4'd6, bases[i], offsets[i]));
    end
    for (int i = 0; i < 5; i++) begin
      appendInst(immInst(op1Lw, 4'd7, bases[i], offsets[i]));
      sendHex(4'd7);
      showLedr(16'(i + 1));
    end
    haltHere();
    restartDut();
    budget = memBudget;
    for (int i = 0; i < 5; i++) begin
      waitForLedr(10'(i + 1), found);
      if (!found) break;
      checkValue("hex", 32'(hex), widenImm(patterns[i]) & 32'h00FFFFFF);
    end
    reportTest("memory", errorsBefore);
  endtask

  task automatic ioTest();
    logic [3:0] keyValue;
    logic [9:0] swValue;
    int         errorsBefore;
    bit         found;
    errorsBefore = errorCount;
    keyValue = 4'(randomBits(4));
    swValue = 10'(randomBits(10));
    clearProgram();
    appendInst(immInst(op1Lw, 4'd8, 4'd0, addrKey[15:0]));
    sendHex(4'd8);
    showLedr(16'd1);
    appendInst(immInst(op1Lw, 4'd9, 4'd0, addrSw[15:0]));
    sendHex(4'd9);
    showLedr(16'd2);
    haltHere();
    keys = keyValue;
    switches = swValue;
    restartDut();
    budget = ioBudget;
    waitForLedr(10'd1, found);
    if (found) checkValue("hex", 32'(hex), {28'h0, ~keyValue});
    waitForLedr(10'd2, found);
    if (found) checkValue("hex", 32'(hex), {22'h0, swValue});
    reportTest("io", errorsBefore);
  endtask

  task automatic illegalTest();
    logic [31:0] haltAddr;
    int          errorsBefore;
    bit          found;
    errorsBefore = errorCount;
    clearProgram();
    showLedr(16'h155);
    // Fetch of the bad word still steps the PC once
    haltAddr = startPc + 32'(4 * progLen) + 32'd4;
    appendInst(32'hFC000000);
    showLedr(16'h2AA);
    haltHere();
    restartDut();
    budget = illegalBudget;
    waitForLedr(10'h155, found);
    if (found) begin
      repeat (2) @(negedge clk);
      for (int i = 0; i < holdCycles && errorCount == errorsBefore; i++) begin
        checkValue("ledr", 32'(ledr), 32'h155);
        checkValue("instAddr", instAddr, haltAddr);
        @(negedge clk);
      end
    end
    reportTest("illegal", errorsBefore);
  endtask

// ==== sim/tbProc.sv ====
`default_nettype none

module tbProc;
  import isaPkg::*;
  import sysPkg::*;

  localparam logic [31:0] startPc = 32'h100;
  localparam int progDepth = 128;
  localparam int resetCycles = 5;
  localparam int margin = 20;

  // Ten cycles for every instruction a test executes
  localparam int aluBudget = 10 * 83 + margin;
  localparam int branchBudget = 10 * 50 + margin;
  localparam int memBudget = 10 * 33 + margin;
  localparam int ioBudget = 10 * 9 + margin;
  localparam int illegalBudget = 10 * 3 + margin;
  localparam int holdCycles = 50;
  localparam int runLimit = 6 * (resetCycles + 1) + 20 + aluBudget + branchBudget
    + memBudget + ioBudget + illegalBudget + holdCycles + 100;

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic [3:0]  keys;
  logic [9:0]  switches;
  logic [31:0] instAddr;
  instWord_t   instWord;
  logic [9:0]  ledr;
  logic [23:0] hex;

  logic [31:0] prog [progDepth];
  int          progLen;
  logic [31:0] fetchOffset;
  logic [6:0]  fetchIdx;
  logic [31:0] lfsrState = 32'he9a0bd45;
  int          errorCount = 0;
  int          passCount = 0;
  int          failCount = 0;
  int          budget = 0;
  int          cycleCount = 0;
  logic [9:0]  ledrExpect [$];

  always #10 clk = ~clk;

  // Instruction port served straight from the program array
  assign fetchOffset = instAddr - startPc;
  assign fetchIdx = fetchOffset[8:2];
  assign instWord = (fetchOffset < 4 * progDepth) ? prog[fetchIdx] : 32'h0;

  procTop UUT (
    .clk(clk), .reset(reset), .instAddr(instAddr), .instWord(instWord),
    .keys(keys), .switches(switches), .ledr(ledr), .hex(hex)
  );

  `include "tbTasks.svh"

  // Hard stop in case a test never sees its result
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > runLimit) begin
      $display("Cycle limit of %0d reached before the tests finished", runLimit);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    keys = '0;
    switches = '0;
    clearProgram();
    @(negedge clk);
    resetTest();
    aluTest();
    branchTest();
    memoryTest();
    ioTest();
    illegalTest();
    $display("Summary: %0d passed, %0d failed", passCount, failCount);
    if (failCount == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/procTop.sv ====
`default_nettype none

module procTop #(
  parameter logic [31:0] startPc = 32'h100,
  parameter int dmemAddrBits = 16
) (
  input  logic                        clk,
  input  logic                        reset,
  output logic [isaPkg::dataBits-1:0] instAddr,
  input  isaPkg::instWord_t           instWord,
  input  logic [sysPkg::keyBits-1:0]  keys,
  input  logic [sysPkg::swBits-1:0]   switches,
  output logic [sysPkg::ledrBits-1:0] ledr,
  output logic [sysPkg::hexBits-1:0]  hex
);
  import isaPkg::*;
  import sysPkg::*;

  ctrlWord_t           ctrl;
  instWord_t           ir;
  logic [dataBits-1:0] bus;
  logic [dataBits-1:0] pc;
  logic [dataBits-1:0] immExt;
  logic [dataBits-1:0] regOut;
  logic [dataBits-1:0] aluOut;
  logic [dataBits-1:0] memIoOut;

  // Shared bus driven by one source per cycle
  always_comb begin
    case (ctrl.busSrc)
      busPc:    bus = pc;
      busImm:   bus = immExt;
      busImmX4: bus = {immExt[dataBits-3:0], 2'b00};
      busReg:   bus = regOut;
      busAlu:   bus = aluOut;
      busMemIo: bus = memIoOut;
      default:  bus = '0;
    endcase
  end

  assign instAddr = pc;

  fetchUnit #(.startPc(startPc)) uFetch (
    .clk(clk), .reset(reset), .ctrl(ctrl), .bus(bus),
    .instWord(instWord), .pc(pc), .ir(ir), .immExt(immExt)
  );

  regFile uRegs (
    .clk(clk), .reset(reset), .ctrl(ctrl), .bus(bus), .regOut(regOut)
  );

  aluUnit uAlu (
    .clk(clk), .ctrl(ctrl), .bus(bus), .aluOut(aluOut)
  );

  dataMemIo #(.dmemAddrBits(dmemAddrBits)) uMem (
    .clk(clk), .reset(reset), .ctrl(ctrl), .bus(bus), .keys(keys),
    .switches(switches), .memIoOut(memIoOut), .ledr(ledr), .hex(hex)
  );

  // Bit 0 carries the comparison result for branches
  controlFsm uCtrl (
    .clk(clk), .reset(reset), .ir(ir), .aluBit(aluOut[0]), .ctrl(ctrl)
  );

endmodule

`default_nettype wire

// ==== rtl/controlFsm.sv ====
`default_nettype none

module controlFsm (
  input  logic              clk,
  input  logic              reset,
  input  isaPkg::instWord_t ir,
  input  logic              aluBit,
  output sysPkg::ctrlWord_t ctrl
);
  import isaPkg::*;
  import sysPkg::*;

  typedef enum logic [4:0] {
    fetch1, fetch2,
    aluR1, aluR2, aluR3,
    aluI1, aluI2, aluI3,
    br1, br2, br3, br4, br5, br6, br7,
    jal1, jal2, jal3, jal4, jal5,
    lw1, lw2, lw3, lw4,
    sw1, sw2, sw3, sw4,
    error
  } state_t;

  state_t state;
  state_t nextState;
  logic   brFlag;

  // Immediate ALU ops and branches both select by op1
  function automatic aluFunc_t funcFromOp1(op1_t op);
    case (op)
      op1Andi: return aluAnd;
      op1Ori:  return aluOr;
      op1Xori: return aluXor;
      op1Beq:  return aluEq;
      op1Blt:  return aluLt;
      op1Ble:  return aluLe;
      op1Bne:  return aluNe;
      default: return aluAdd;
    endcase
  endfunction

  function automatic aluFunc_t funcFromOp2(op2_t op);
    case (op)
      op2Eq:   return aluEq;
      op2Lt:   return aluLt;
      op2Le:   return aluLe;
      op2Ne:   return aluNe;
      op2And:  return aluAnd;
      op2Or:   return aluOr;
      op2Xor:  return aluXor;
      op2Sub:  return aluSub;
      op2Nand: return aluNand;
      op2Nor:  return aluNor;
      op2Nxor: return aluNxor;
      default: return aluAdd;
    endcase
  endfunction

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= fetch1;
      brFlag <= 1'b0;
    end else begin
      state <= nextState;
      if (state == br3) begin
        brFlag <= aluBit;
      end
    end
  end

  // Microcode mostly walks the states in order
  always_comb begin
    nextState = state_t'(state + 5'd1);
    case (state)
      fetch2: begin
        case (ir.regForm.op1)
          op1Ext: begin
            case (ir.regForm.op2)
              op2Eq, op2Lt, op2Le, op2Ne, op2Add, op2And,
              op2Or, op2Xor, op2Sub, op2Nand, op2Nor, op2Nxor: nextState = aluR1;
              default: nextState = error;
            endcase
          end
          op1Beq, op1Blt, op1Ble, op1Bne:   nextState = br1;
          op1Addi, op1Andi, op1Ori, op1Xori: nextState = aluI1;
          op1Jal:  nextState = jal1;
          op1Lw:   nextState = lw1;
          op1Sw:   nextState = sw1;
          default: nextState = error;
        endcase
      end
      aluR3, aluI3, br7, jal5, lw4, sw4: nextState = fetch1;
      br4:     nextState = brFlag ? br5 : fetch1;
      error:   nextState = error;
      default: ;
    endcase
  end

  always_comb begin
    ctrl = '0;
    ctrl.busSrc = busNone;
    ctrl.aluFunc = aluEq;
    case (state)
      fetch1: begin
        ctrl.ldIr = 1'b1;
        ctrl.incPc = 1'b1;
      end
      // rs into A
      aluR1, aluI1, br1, jal2, lw1, sw1: begin
        ctrl.busSrc = busReg;
        ctrl.regNo = ir.regForm.rs;
        ctrl.ldA = 1'b1;
      end
      aluR2, br2: begin
        ctrl.busSrc = busReg;
        ctrl.regNo = ir.regForm.rt;
        ctrl.ldB = 1'b1;
      end
      aluI2, lw2, sw2: begin
        ctrl.busSrc = busImm;
        ctrl.ldB = 1'b1;
      end
      aluR3: begin
        ctrl.busSrc = busAlu;
        ctrl.aluFunc = funcFromOp2(ir.regForm.op2);
        ctrl.regNo = ir.regForm.rd;
        ctrl.wrReg = 1'b1;
      end
      aluI3: begin
        ctrl.busSrc = busAlu;
        ctrl.aluFunc = funcFromOp1(ir.immForm.op1);
        ctrl.regNo = ir.immForm.rt;
        ctrl.wrReg = 1'b1;
      end
      br3: ctrl.aluFunc = funcFromOp1(ir.immForm.op1);
      // Target is the already incremented PC plus offset
      br5: begin
        ctrl.busSrc = busPc;
        ctrl.ldA = 1'b1;
      end
      br6, jal3: begin
        ctrl.busSrc = busImmX4;
        ctrl.ldB = 1'b1;
      end
      br7, jal4: begin
        ctrl.busSrc = busAlu;
        ctrl.aluFunc = aluAdd;
        ctrl.ldPc = 1'b1;
      end
      jal1: begin
        ctrl.busSrc = busPc;
        ctrl.regNo = ir.immForm.rt;
        ctrl.wrReg = 1'b1;
      end
      lw3, sw3: begin
        ctrl.busSrc = busAlu;
        ctrl.aluFunc = aluAdd;
        ctrl.ldMar = 1'b1;
      end
      lw4: begin
        ctrl.busSrc = busMemIo;
        ctrl.regNo = ir.immForm.rt;
        ctrl.wrReg = 1'b1;
      end
      sw4: begin
        ctrl.busSrc = busReg;
        ctrl.regNo = ir.immForm.rt;
        ctrl.wrMem = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/dataMemIo.sv ====
`default_nettype none

module dataMemIo #(
  parameter int dmemAddrBits = 16
) (
  input  logic                        clk,
  input  logic                        reset,
  input  sysPkg::ctrlWord_t           ctrl,
  input  logic [isaPkg::dataBits-1:0] bus,
  input  logic [sysPkg::keyBits-1:0]  keys,
  input  logic [sysPkg::swBits-1:0]   switches,
  output logic [isaPkg::dataBits-1:0] memIoOut,
  output logic [sysPkg::ledrBits-1:0] ledr,
  output logic [sysPkg::hexBits-1:0]  hex
);
  import isaPkg::*;
  import sysPkg::*;

  localparam int memWords = 2 ** (dmemAddrBits - 2);

  logic [dataBits-1:0]     mar;
  logic [dataBits-1:0]     mem [memWords];
  logic                    memSel;
  logic [dmemAddrBits-3:0] wordIdx;

  // Anything above the memory range is I/O space
  assign memSel = (mar[dataBits-1:dmemAddrBits] == '0);
  assign wordIdx = mar[dmemAddrBits-1:2];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mar <= '0;
    end else if (ctrl.ldMar) begin
      mar <= bus;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.wrMem && memSel) begin
      mem[wordIdx] <= bus;
    end
  end

  // Writes elsewhere in I/O space fall through
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ledr <= '0;
      hex <= '0;
    end else if (ctrl.wrMem && !memSel) begin
      if (mar == addrLedr) begin
        ledr <= bus[ledrBits-1:0];
      end
      if (mar == addrHex) begin
        hex <= bus[hexBits-1:0];
      end
    end
  end

  always_comb begin
    if (memSel) begin
      memIoOut = mem[wordIdx];
    end else if (mar == addrKey) begin
      // Keys are active low on the board
      memIoOut = {{(dataBits - keyBits){1'b0}}, ~keys};
    end else if (mar == addrSw) begin
      memIoOut = {{(dataBits - swBits){1'b0}}, switches};
    end else begin
      memIoOut = '0;
    end
  end

  // A store always uses the address latched in an earlier step
  marStable: assert property (
    @(posedge clk) disable iff (reset) !(ctrl.ldMar && ctrl.wrMem)
  ) else $error("ldMar and wrMem active in the same cycle");

endmodule

`default_nettype wire

// ==== rtl/aluUnit.sv ====
`default_nettype none

module aluUnit (
  input  logic                        clk,
  input  sysPkg::ctrlWord_t           ctrl,
  input  logic [isaPkg::dataBits-1:0] bus,
  output logic [isaPkg::dataBits-1:0] aluOut
);
  import isaPkg::*;
  import sysPkg::*;

  logic signed [dataBits-1:0] a;
  logic signed [dataBits-1:0] b;

  // Operand latches
  always_ff @(posedge clk) begin
    if (ctrl.ldA) begin
      a <= bus;
    end
    if (ctrl.ldB) begin
      b <= bus;
    end
  end

  always_comb begin
    case (ctrl.aluFunc)
      aluEq:   aluOut = {{(dataBits - 1){1'b0}}, a == b};
      aluLt:   aluOut = {{(dataBits - 1){1'b0}}, a < b};
      aluLe:   aluOut = {{(dataBits - 1){1'b0}}, a <= b};
      aluNe:   aluOut = {{(dataBits - 1){1'b0}}, a != b};
      aluAdd:  aluOut = a + b;
      aluAnd:  aluOut = a & b;
      aluOr:   aluOut = a | b;
      aluXor:  aluOut = a ^ b;
      aluSub:  aluOut = a - b;
      aluNand: aluOut = ~(a & b);
      aluNor:  aluOut = ~(a | b);
      aluNxor: aluOut = ~(a ^ b);
      default: aluOut = '0;
    endcase
  end

  // The FSM has to select a real function whenever the result is used
  aluFuncKnown: assert property (
    @(posedge clk) ctrl.busSrc == busAlu |-> !$isunknown(ctrl.aluFunc)
  ) else $error("ALU drives the bus with an unknown function");

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
`default_nettype none

module regFile (
  input  logic                        clk,
  input  logic                        reset,
  input  sysPkg::ctrlWord_t           ctrl,
  input  logic [isaPkg::dataBits-1:0] bus,
  output logic [isaPkg::dataBits-1:0] regOut
);
  import isaPkg::*;
  import sysPkg::*;

  localparam int numRegs = 2 ** regNoBits;

  logic [dataBits-1:0] regs [numRegs];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.wrReg) begin
      regs[ctrl.regNo] <= bus;
    end
  end

  // Read and write share regNo on the single port
  assign regOut = regs[ctrl.regNo];

  // A register never writes its own value back through the bus
  noSelfWrite: assert property (
    @(posedge clk) disable iff (reset) !(ctrl.wrReg && ctrl.busSrc == busReg)
  ) else $error("wrReg while the register file drives the bus");

endmodule

`default_nettype wire

// ==== rtl/fetchUnit.sv ====
`default_nettype none

module fetchUnit #(
  parameter logic [31:0] startPc = 32'h100
) (
  input  logic                         clk,
  input  logic                         reset,
  input  sysPkg::ctrlWord_t            ctrl,
  input  logic [isaPkg::dataBits-1:0]  bus,
  input  isaPkg::instWord_t            instWord,
  output logic [isaPkg::dataBits-1:0]  pc,
  output isaPkg::instWord_t            ir,
  output logic [isaPkg::dataBits-1:0]  immExt
);
  import isaPkg::*;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= startPc;
    end else if (ctrl.ldPc) begin
      pc <= bus;
    end else if (ctrl.incPc) begin
      pc <= pc + instSize;
    end
  end

  // IR comes straight from the fetch port, not the bus
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ir <= '0;
    end else if (ctrl.ldIr) begin
      ir <= instWord;
    end
  end

  assign immExt = {{(dataBits - immBits){ir.immForm.imm[immBits-1]}}, ir.immForm.imm};

  // Microcode must pick one PC update per cycle
  pcUpdateOneHot: assert property (
    @(posedge clk) disable iff (reset) !(ctrl.ldPc && ctrl.incPc)
  ) else $error("ldPc and incPc active in the same cycle");

endmodule

`default_nettype wire

// ==== rtl/sysPkg.sv ====
`default_nettype none

package sysPkg;

  // Memory-mapped I/O sits above the data memory range
  localparam logic [isaPkg::dataBits-1:0] addrHex  = 32'hFFFFF000;
  localparam logic [isaPkg::dataBits-1:0] addrLedr = 32'hFFFFF020;
  localparam logic [isaPkg::dataBits-1:0] addrKey  = 32'hFFFFF080;
  localparam logic [isaPkg::dataBits-1:0] addrSw   = 32'hFFFFF090;

  localparam int ledrBits = 10;
  localparam int hexBits = 24;
  localparam int keyBits = 4;
  localparam int swBits = 10;

  typedef enum logic [2:0] {
    busNone,
    busPc,
    busImm,
    busImmX4,
    busReg,
    busAlu,
    busMemIo
  } busSrc_t;

  // One microcode step
  typedef struct packed {
    logic                         ldPc;
    logic                         incPc;
    logic                         ldIr;
    busSrc_t                      busSrc;
    logic                         ldA;
    logic                         ldB;
    isaPkg::aluFunc_t             aluFunc;
    logic [isaPkg::regNoBits-1:0] regNo;
    logic                         wrReg;
    logic                         ldMar;
    logic                         wrMem;
  } ctrlWord_t;

endpackage

`default_nettype wire

// ==== rtl/isaPkg.sv ====
`default_nettype none

package isaPkg;

  localparam int dataBits = 32;
  localparam int regNoBits = 4;
  localparam int immBits = 16;
  localparam logic [dataBits-1:0] instSize = 32'd4;

  // Primary opcode in bits 31..26
  typedef enum logic [5:0] {
    op1Ext  = 6'b000000,
    op1Beq  = 6'b001000,
    op1Blt  = 6'b001001,
    op1Ble  = 6'b001010,
    op1Bne  = 6'b001011,
    op1Jal  = 6'b001100,
    op1Lw   = 6'b010010,
    op1Sw   = 6'b011010,
    op1Addi = 6'b100000,
    op1Andi = 6'b100100,
    op1Ori  = 6'b100101,
    op1Xori = 6'b100110
  } op1_t;

  // Secondary opcode only meaningful under op1Ext
  typedef enum logic [7:0] {
    op2Eq   = 8'b00001000,
    op2Lt   = 8'b00001001,
    op2Le   = 8'b00001010,
    op2Ne   = 8'b00001011,
    op2Add  = 8'b00100000,
    op2And  = 8'b00100100,
    op2Or   = 8'b00100101,
    op2Xor  = 8'b00100110,
    op2Sub  = 8'b00101000,
    op2Nand = 8'b00101100,
    op2Nor  = 8'b00101101,
    op2Nxor = 8'b00101110
  } op2_t;

  typedef enum logic [3:0] {
    aluEq, aluLt, aluLe, aluNe,
    aluAdd, aluAnd, aluOr, aluXor,
    aluSub, aluNand, aluNor, aluNxor
  } aluFunc_t;

  typedef struct packed {
    op1_t                 op1;
    op2_t                 op2;
    logic [5:0]           unused;
    logic [regNoBits-1:0] rd;
    logic [regNoBits-1:0] rs;
    logic [regNoBits-1:0] rt;
  } regForm_t;

  typedef struct packed {
    op1_t                 op1;
    logic [1:0]           unused;
    logic [immBits-1:0]   imm;
    logic [regNoBits-1:0] rs;
    logic [regNoBits-1:0] rt;
  } immForm_t;

  // rs and rt sit in the same bits in both views
  typedef union packed {
    regForm_t regForm;
    immForm_t immForm;
  } instWord_t;

endpackage

`default_nettype wire
